/* hdl/conv_pkg.sv */
package conv_pkg;

    ////////////////////////////////////////
    // tile geometry
    ////////////////////////////////////////

    parameter int POX_DEF = 4;  // output columns
    parameter int POF_DEF = 4;  // output channels

    ////////////////////////////////////////
    // datapath widths
    ////////////////////////////////////////

    parameter int PIX_W  = 8;   // pixel, weight, bias, quantized out
    parameter int ACC_W  = 24;  // 16b product + headroom
    parameter int TAIL_W = 16;  // e-scale tail, unsigned
    parameter int RANK_W = 5;   // e-scale shift rank
    parameter int PROD_W = 40;  // biased acc times tail
    parameter int CNT_W  = 16;  // beat count, nif*k*k

    typedef logic signed [PIX_W-1:0] pix_t;
    typedef logic signed [PIX_W-1:0] wgt_t;
    typedef logic signed [PIX_W-1:0] qpix_t;
    typedef logic signed [ACC_W-1:0] acc_t;

    // per-channel quantization entry
    typedef struct packed {
        logic signed [PIX_W-1:0] bias;
        logic [TAIL_W-1:0]       tail;
        logic [RANK_W-1:0]       rank;
    } quant_param_s;

    // controller states
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACCUM,
        ST_DRAIN
    } sa_state_e;

endpackage

/* hdl/sa_ctrl.sv */
`timescale 1ns/1ns

module sa_ctrl import conv_pkg::*; #(
    parameter int POF = POF_DEF
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  logic [CNT_W-1:0]       nkk,
    input  logic                   in_valid,
    output logic                   busy,
    output logic                   acc_clr,
    output logic                   acc_en,
    output logic [$clog2(POF)-1:0] drain_idx,
    output logic                   drain_valid,
    output logic                   drain_last
);

    localparam int F_W = $clog2(POF);

    sa_state_e        state;
    logic [CNT_W-1:0] beat_cnt;  // accepted beats this tile
    logic [CNT_W-1:0] nkk_q;
    logic             beat_end;

    assign busy        = (state != ST_IDLE);
    assign acc_clr     = (state == ST_IDLE) && start;
    assign acc_en      = (state == ST_ACCUM) && in_valid;  // stray beats dropped
    assign beat_end    = acc_en && (CNT_W'(beat_cnt + 1'b1) == nkk_q);
    assign drain_valid = (state == ST_DRAIN);
    assign drain_last  = drain_valid && (drain_idx == F_W'(POF - 1));

    // beat target, held for the whole tile
    always_ff @(posedge clk) begin
        if (acc_clr) begin
            nkk_q <= nkk;
        end
    end

    ////////////////////////////////////////
    // tile fsm
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_IDLE;
            beat_cnt  <= '0;
            drain_idx <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start) begin
                        state    <= ST_ACCUM;
                        beat_cnt <= '0;
                    end
                end
                ST_ACCUM: begin
                    if (acc_en) begin
                        beat_cnt <= beat_cnt + 1'b1;
                    end
                    if (beat_end) begin
                        state     <= ST_DRAIN;
                        drain_idx <= '0;  // first channel row
                    end
                end
                ST_DRAIN: begin
                    drain_idx <= drain_idx + 1'b1;
                    if (drain_last) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

endmodule

/* hdl/pe_array.sv */
`timescale 1ns/1ns

module pe_array import conv_pkg::*; #(
    parameter int POX = POX_DEF,
    parameter int POF = POF_DEF
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   acc_clr,
    input  logic                   acc_en,
    input  pix_t [POX-1:0]         in_pix,
    input  wgt_t [POF-1:0]         in_wgt,
    input  logic [$clog2(POF)-1:0] drain_idx,
    output acc_t [POX-1:0]         drain_row
);

    acc_t acc [POF][POX];  // cell (f, x)

    ////////////////////////////////////////
    // mac grid, operands broadcast
    ////////////////////////////////////////

    for (genvar f = 0; f < POF; f++) begin : g_chan
        for (genvar x = 0; x < POX; x++) begin : g_col
            always_ff @(posedge clk) begin
                if (rst || acc_clr) begin
                    acc[f][x] <= '0;
                end else if (acc_en) begin
                    // pixel of column x times weight of channel f
                    acc[f][x] <= acc[f][x] + acc_t'(in_pix[x]) * acc_t'(in_wgt[f]);
                end
            end
        end
    end

    ////////////////////////////////////////
    // drain row select
    ////////////////////////////////////////

    always_comb begin
        for (int x = 0; x < POX; x++) begin
            drain_row[x] = acc[drain_idx][x];
        end
    end

endmodule

/* hdl/quant_param_regs.sv */
`timescale 1ns/1ns

module quant_param_regs import conv_pkg::*; #(
    parameter int POF = POF_DEF
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   busy,
    input  logic                   param_wr,
    input  logic [$clog2(POF)-1:0] param_idx,
    input  quant_param_s           param,
    input  logic [$clog2(POF)-1:0] drain_idx,
    output quant_param_s           drain_param
);

    quant_param_s regs [POF];  // bias, tail, rank per channel

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int f = 0; f < POF; f++) begin
                regs[f] <= '0;
            end
        end else if (param_wr && !busy) begin
            regs[param_idx] <= param;
        end
    end

    // read port follows the drain walk
    assign drain_param = regs[drain_idx];

endmodule

/* hdl/post_proc.sv */
`timescale 1ns/1ns

module post_proc import conv_pkg::*; #(
    parameter int POX = POX_DEF,
    parameter int POF = POF_DEF
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   drain_valid,
    input  logic                   drain_last,
    input  logic [$clog2(POF)-1:0] drain_idx,
    input  acc_t [POX-1:0]         drain_row,
    input  quant_param_s           drain_param,
    output logic                   out_valid,
    output logic [$clog2(POF)-1:0] out_f_idx,
    output qpix_t [POX-1:0]        out_data,
    output logic                   done
);

    typedef logic signed [PROD_W-1:0] prod_t;

    // round half up, arithmetic shift, clamp to 8 bits
    function automatic qpix_t quantize(prod_t p, logic [RANK_W-1:0] rank);
        logic signed [PROD_W:0] half;
        logic signed [PROD_W:0] r;
        half = '0;
        if (rank != '0) begin
            half = {{PROD_W{1'b0}}, 1'b1} << (rank - 1'b1);
        end
        r = (PROD_W + 1)'(p) + half;  // one spare bit for the round carry
        r = r >>> rank;
        if (r > 127) begin
            return qpix_t'(127);
        end else if (r < -128) begin
            return qpix_t'(-128);
        end
        return qpix_t'(r);
    endfunction

    logic                   s1_valid;
    logic                   s1_last;
    logic [$clog2(POF)-1:0] s1_idx;
    logic [RANK_W-1:0]      s1_rank;
    prod_t                  s1_prod [POX];

    ////////////////////////////////////////
    // stage 1, bias add and tail multiply
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s1_last  <= 1'b0;
        end else begin
            s1_valid <= drain_valid;
            s1_last  <= drain_last;
        end
    end

    always_ff @(posedge clk) begin
        s1_idx  <= drain_idx;
        s1_rank <= drain_param.rank;
        for (int x = 0; x < POX; x++) begin
            // tail zero-extended so the product stays signed
            s1_prod[x] <= prod_t'(drain_row[x] + acc_t'(drain_param.bias))
                        * prod_t'({1'b0, drain_param.tail});
        end
    end

    ////////////////////////////////////////
    // stage 2, round, shift, saturate
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            done      <= 1'b0;
        end else begin
            out_valid <= s1_valid;
            done      <= s1_valid && s1_last;  // last channel row of the tile
        end
    end

    always_ff @(posedge clk) begin
        out_f_idx <= s1_idx;
        for (int x = 0; x < POX; x++) begin
            out_data[x] <= quantize(s1_prod[x], s1_rank);
        end
    end

endmodule

/* hdl/conv_core.sv */
`timescale 1ns/1ns

module conv_core import conv_pkg::*; #(
    parameter int POX = POX_DEF,
    parameter int POF = POF_DEF
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start,
    input  logic [CNT_W-1:0]       nkk,
    input  logic                   in_valid,
    input  pix_t [POX-1:0]         in_pix,
    input  wgt_t [POF-1:0]         in_wgt,
    input  logic                   param_wr,
    input  logic [$clog2(POF)-1:0] param_idx,
    input  quant_param_s           param,
    output logic                   busy,
    output logic                   out_valid,
    output logic [$clog2(POF)-1:0] out_f_idx,
    output qpix_t [POX-1:0]        out_data,
    output logic                   done
);

    localparam int F_W = $clog2(POF);

    logic           acc_clr;
    logic           acc_en;
    logic [F_W-1:0] drain_idx;
    logic           drain_valid;
    logic           drain_last;
    acc_t [POX-1:0] drain_row;
    quant_param_s   drain_param;

    sa_ctrl #(.POF(POF)) u_sa_ctrl (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .nkk         (nkk),
        .in_valid    (in_valid),
        .busy        (busy),
        .acc_clr     (acc_clr),
        .acc_en      (acc_en),
        .drain_idx   (drain_idx),
        .drain_valid (drain_valid),
        .drain_last  (drain_last)
    );

    pe_array #(.POX(POX), .POF(POF)) u_pe_array (
        .clk       (clk),
        .rst       (rst),
        .acc_clr   (acc_clr),
        .acc_en    (acc_en),
        .in_pix    (in_pix),
        .in_wgt    (in_wgt),
        .drain_idx (drain_idx),
        .drain_row (drain_row)
    );

    quant_param_regs #(.POF(POF)) u_quant_param_regs (
        .clk         (clk),
        .rst         (rst),
        .busy        (busy),     // writes locked out during a tile
        .param_wr    (param_wr),
        .param_idx   (param_idx),
        .param       (param),
        .drain_idx   (drain_idx),
        .drain_param (drain_param)
    );

    post_proc #(.POX(POX), .POF(POF)) u_post_proc (
        .clk         (clk),
        .rst         (rst),
        .drain_valid (drain_valid),
        .drain_last  (drain_last),
        .drain_idx   (drain_idx),
        .drain_row   (drain_row),
        .drain_param (drain_param),
        .out_valid   (out_valid),
        .out_f_idx   (out_f_idx),
        .out_data    (out_data),
        .done        (done)
    );

endmodule

/* dv/clk_gen.sv */
`timescale 1ns/1ns

module clk_gen #(
    parameter int PERIOD     = 20,
    parameter int RST_CYCLES = 2
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // release lines up with the stimulus offset
    initial begin
        rst = 1'b1;
        repeat (RST_CYCLES) @(posedge clk);
        #2 rst = 1'b0;
    end

endmodule

/* dv/conv_core_tb.sv */
`timescale 1ns/1ns

module conv_core_tb import conv_pkg::*;;

    localparam int POX = POX_DEF;
    localparam int POF = POF_DEF;
    localparam int F_W = $clog2(POF);

    logic clk, rst, start, in_valid, param_wr, busy, out_valid, done;
    logic [CNT_W-1:0] nkk;
    pix_t [POX-1:0]   in_pix;
    wgt_t [POF-1:0]   in_wgt;
    logic [F_W-1:0]   param_idx, out_f_idx, exp_idx;
    quant_param_s     param;
    qpix_t [POX-1:0]  out_data;

    logic [POF-1:0][POX-1:0][7:0] exp_out;  // model rows, by channel
    quant_param_s prm [POF];                // model copy of the param regs
    pix_t pix_mem [16][POX];
    wgt_t wgt_mem [16][POF];
    logic [31:0] lfsr = 32'h92ef_75f8;
    int errors = 0, tests = 0, fails = 0;

    clk_gen u_clk_gen (.clk(clk), .rst(rst));

    conv_core #(.POX(POX), .POF(POF)) uut (.*);

    ////////////////////////////////////////
    // output checks
    ////////////////////////////////////////

    always @(posedge clk) begin
        if (rst) exp_idx <= '0;
        else if (out_valid) exp_idx <= (exp_idx == F_W'(POF - 1)) ? '0 : exp_idx + 1'b1;
    end

    assert property (@(posedge clk) disable iff (rst)
                     out_valid |-> out_data == exp_out[exp_idx])
        else begin
            errors++;
            $display("[FAIL] %0t: channel %0d data %h, expected %h", $time,
                     $sampled(exp_idx), $sampled(out_data), exp_out[$sampled(exp_idx)]);
        end
    assert property (@(posedge clk) disable iff (rst) out_valid |-> out_f_idx == exp_idx)
        else begin
            errors++;
            $display("[FAIL] %0t: channel index %0d, expected %0d", $time,
                     $sampled(out_f_idx), $sampled(exp_idx));
        end
    assert property (@(posedge clk) disable iff (rst)
                     done |-> out_valid && out_f_idx == F_W'(POF - 1))
        else begin
            errors++;
            $display("[FAIL] %0t: done without the last channel beat", $time);
        end
    // no holes inside one drain burst
    assert property (@(posedge clk) disable iff (rst)
                     out_valid && out_f_idx != F_W'(POF - 1) |=> out_valid)
        else begin
            errors++;
            $display("[FAIL] %0t: gap in the output burst", $time);
        end
    // busy from the cycle after start, low again once the drain is over
    assert property (@(posedge clk) disable iff (rst) start && !busy |=> busy)
        else begin
            errors++;
            $display("[FAIL] %0t: busy low after a start", $time);
        end
    assert property (@(posedge clk) disable iff (rst) done |-> !busy)
        else begin
            errors++;
            $display("[FAIL] %0t: busy still high with done", $time);
        end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    function automatic logic [31:0] rand_bits(int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};  // taps 32 22 2 1
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // bias, tail, round, shift, clamp
    function automatic logic [7:0] model_quant(longint a, quant_param_s q);
        longint p;
        p = (a + longint'($signed(q.bias))) * longint'(q.tail);
        if (q.rank != 0) p = p + (longint'(1) << (q.rank - 1));
        p = p >>> q.rank;
        if (p > 127) p = 127;
        else if (p < -128) p = -128;
        return p[7:0];
    endfunction

    task automatic set_param(int f, logic [7:0] bias, logic [15:0] tail, logic [4:0] rank);
        @(posedge clk);
        #2;
        prm[f] = '{bias: bias, tail: tail, rank: rank};
        param_wr = 1'b1;
        param_idx = F_W'(f);
        param = prm[f];
        @(posedge clk);
        #2 param_wr = 1'b0;
    endtask

    task automatic run_tile(int n, bit gaps, bit stray, bit wr_busy);
        longint m [POF][POX];
        int b, cnt;
        for (b = 0; b < n; b++) begin
            for (int x = 0; x < POX; x++) pix_mem[b][x] = pix_t'(rand_bits(8));
            for (int f = 0; f < POF; f++) wgt_mem[b][f] = wgt_t'(rand_bits(8));
        end
        for (int f = 0; f < POF; f++) begin
            for (int x = 0; x < POX; x++) begin
                m[f][x] = 0;
                for (b = 0; b < n; b++) begin
                    m[f][x] += longint'(pix_mem[b][x]) * longint'(wgt_mem[b][f]);
                end
                exp_out[f][x] = model_quant(m[f][x], prm[f]);
            end
        end
        @(posedge clk);
        #2;
        start = 1'b1;
        nkk = CNT_W'(n);
        in_valid = stray;  // beat offered while still idle
        in_pix = {POX{8'h7f}};
        b = 0;
        while (b < n) begin
            @(posedge clk);
            #2;
            start = 1'b0;
            param_wr = wr_busy && b == 0;
            param_idx = '0;
            param = ~prm[0];
            if (gaps && rand_bits(1)) begin
                in_valid = 1'b0;
            end else begin
                in_valid = 1'b1;
                for (int x = 0; x < POX; x++) in_pix[x] = pix_mem[b][x];
                for (int f = 0; f < POF; f++) in_wgt[f] = wgt_mem[b][f];
                b++;
            end
        end
        cnt = 0;
        for (int i = 0; i < 40; i++) begin
            @(posedge clk);
            #1;
            if (out_valid) cnt++;
            if (done) break;
            #1;
            in_valid = stray && i < 2;  // beats during the drain
            param_wr = 1'b0;
        end
        if (!done) begin
            $display("timeout at %0t: no done after %0d beats", $time, n);
            $display("Some tests failed");
            $finish;
        end
        assert (cnt == POF) else begin
            errors++;
            $display("[FAIL] %0t: %0d output beats, expected %0d", $time, cnt, POF);
        end
        // last beat is checked on the next edge, rows must hold till then
        @(posedge clk);
        #2 in_valid = 1'b0;
    endtask

    task automatic end_test(string name, int err0);
        tests++;
        if (errors != err0) fails++;
        $display("%s: %s", name, (errors == err0) ? "ok" : "FAILED");
    endtask

    ////////////////////////////////////////
    // sequence
    ////////////////////////////////////////

    initial begin
        int err0, w;
        start = 1'b0;
        nkk = '0;
        in_valid = 1'b0;
        in_pix = '0;
        in_wgt = '0;
        param_wr = 1'b0;
        param_idx = '0;
        param = '0;
        exp_out = '0;
        foreach (prm[f]) prm[f] = '0;
        w = 0;
        do begin
            @(posedge clk);
            w++;
        end while (rst && w < 20);
        if (rst) begin
            $display("timeout at %0t: reset never released", $time);
            $display("Some tests failed");
            $finish;
        end
        err0 = errors;
        repeat (5) begin
            @(posedge clk);
            #1;
            assert (!busy && !out_valid && !done) else begin
                errors++;
                $display("[FAIL] %0t: status high before the first start", $time);
            end
        end
        end_test("reset idle", err0);

        err0 = errors;
        for (int f = 0; f < POF; f++) set_param(f, 8'd0, 16'd1, 5'd0);
        run_tile(1, 0, 0, 0);
        run_tile(1, 0, 0, 0);
        end_test("single beat identity", err0);

        err0 = errors;
        for (int f = 0; f < POF; f++) set_param(f, 8'd0, 16'd1, 5'd8);
        run_tile(9, 0, 0, 0);
        run_tile(9, 1, 1, 0);
        run_tile(9, 1, 1, 0);
        end_test("multi beat accumulation", err0);

        err0 = errors;
        for (int t = 0; t < 6; t++) begin
            for (int f = 0; f < POF; f++) begin
                set_param(f, 8'(rand_bits(8)), 16'(rand_bits(16)), 5'(rand_bits(5)));
            end
            run_tile(9, 1, 0, 1);
        end
        end_test("quantization", err0);

        err0 = errors;
        for (int f = 0; f < POF; f++) set_param(f, 8'd0, 16'd1, 5'd7);
        run_tile(3, 0, 0, 0);
        run_tile(2, 0, 1, 0);  // earlier sums must be gone
        end_test("ordering and restart", err0);

        $display("tests %0d, failed %0d, errors %0d", tests, fails, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* conv_core.f */
hdl/conv_pkg.sv
hdl/sa_ctrl.sv
hdl/pe_array.sv
hdl/quant_param_regs.sv
hdl/post_proc.sv
hdl/conv_core.sv
dv/clk_gen.sv
dv/conv_core_tb.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module conv_core_tb -f conv_core.f -o sim_conv_core \
    && ./obj_dir/sim_conv_core > sim.log 2>&1 \
    || echo "build or run error" >> sim.log

cat sim.log
grep -q "All tests passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
